/* hdl/hub_consts.svh */
// board hub constants
// frame size, register map, peripheral count, pin sync depth

`ifndef HUB_CONSTS_SVH
`define HUB_CONSTS_SVH

// spi frame, address byte then data byte
`define HUB_FRAME_BITS 16

// routed peripherals behind cs2
`define HUB_NUM_PERIPH 5

// flops in each spi pin synchronizer
`define HUB_SYNC_STAGES 2

//////////////////////////////////////////////////////////////
// register map, address byte values

`define HUB_ADDR_POWERUP    8'd6
`define HUB_ADDR_LED        8'd7
`define HUB_ADDR_MUX        8'd8
`define HUB_ADDR_DAC        8'd9
`define HUB_ADDR_SOFT_RESET 8'd11
`define HUB_ADDR_ADC        8'd14

`endif

/* hdl/spi_frame_pkg.sv */
// spi frame types
// address/data frame and the two views of the data byte

`default_nettype none

package spi_frame_pkg;

  //////////////////////////////////////////////////////////////
  // data byte, bit register view

  // clear in high nibble, set in low nibble
  // both set for one bit means toggle
  typedef struct packed {
    logic [3:0] clear;
    logic [3:0] set;
  } nibble_pair_t;

  //////////////////////////////////////////////////////////////
  // data byte, both views

  // bits for led/dac/adc, sel for the mux register
  // sel of n selects peripheral n-1, zero selects none
  typedef union packed {
    nibble_pair_t bits;
    logic [7:0]   sel;
  } frame_data_u;

  //////////////////////////////////////////////////////////////
  // full frame as seen on mosi, msb first

  typedef struct packed {
    logic [7:0]  addr;
    frame_data_u data;
  } spi_frame_t;

endpackage

`default_nettype wire

/* hdl/board_ctrl_pkg.sv */
// board control types
// register set and peripheral select vectors

`default_nettype none

`include "hub_consts.svh"

package board_ctrl_pkg;

  //////////////////////////////////////////////////////////////
  // control register set

  // led     front panel leds
  // mux     one-hot peripheral select, zero for none
  // dac     ldac, uni/bip a, uni/bip b, rst
  // adc     mode pins m0..m2, rst
  typedef struct packed {
    logic [3:0] led;
    logic [7:0] mux;
    logic [3:0] dac;
    logic [3:0] adc;
  } ctrl_regs_t;

  //////////////////////////////////////////////////////////////
  // one bit per routed peripheral

  // used for cs_n, sck, mosi and miso fan-out
  // bit 0 pairs with mux bit 0
  typedef logic [`HUB_NUM_PERIPH-1:0] periph_vec_t;

endpackage

`default_nettype wire

/* hdl/spi_target.sv */
// spi target for the register bank
// pin sync, frame shift-in, reply shift-out, valid/ready frame handoff

`default_nettype none
`timescale 1ns/1ns

`include "hub_consts.svh"

module spi_target (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       sck,
  input  wire                       cs_n,
  input  wire                       mosi,
  output logic                      dout,
  output spi_frame_pkg::spi_frame_t frame,
  output logic                      frame_valid,
  input  wire                       frame_ready,
  output logic [7:0]                rd_addr,
  output logic                      rd_req,
  input  wire  [7:0]                rd_data
);

  localparam int CNT_W = $clog2(`HUB_FRAME_BITS) + 1;
  localparam int ADDR_BITS = `HUB_FRAME_BITS / 2;

  // raw pins, kept together through the sync chain
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  localparam spi_pins_t PINS_IDLE = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0};

  spi_pins_t [`HUB_SYNC_STAGES-1:0] pin_sync;
  spi_pins_t                        pins_s;
  spi_pins_t                        pins_d;

  logic                       sck_rise;
  logic                       sck_fall;
  logic                       cs_rise;
  logic                       frame_done;
  logic                       load_frame;
  logic [CNT_W-1:0]           bit_cnt;
  logic [`HUB_FRAME_BITS-1:0] frame_sr;
  logic [7:0]                 reply_sr;

  //////////////////////////////////////////////////////////////
  // pin sync and edge detect

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pin_sync <= {`HUB_SYNC_STAGES{PINS_IDLE}};
      pins_d   <= PINS_IDLE;
    end
    else
    begin
      pin_sync <= {pin_sync[`HUB_SYNC_STAGES-2:0], spi_pins_t'{sck, cs_n, mosi}};
      pins_d   <= pins_s;
    end
  end

  assign pins_s   = pin_sync[`HUB_SYNC_STAGES-1];
  assign sck_rise = pins_s.sck & ~pins_d.sck & ~pins_s.cs_n;
  assign sck_fall = ~pins_s.sck & pins_d.sck & ~pins_s.cs_n;
  // cs release, two sync stages in, frame_valid one flop later
  assign cs_rise  = pins_s.cs_n & ~pins_d.cs_n;

  //////////////////////////////////////////////////////////////
  // bit counter and mosi shift-in

  always_ff @(posedge clk)
  begin
    if (reset || pins_s.cs_n)
      bit_cnt <= '0;
    // saturate, long frames must not wrap back to 16
    else if (sck_rise && bit_cnt != {CNT_W{1'b1}})
      bit_cnt <= bit_cnt + 1'b1;
  end

  // msb first, address lands in the low byte after 8 bits
  always_ff @(posedge clk)
  begin
    if (sck_rise)
      frame_sr <= {frame_sr[`HUB_FRAME_BITS-2:0], pins_s.mosi};
  end

  //////////////////////////////////////////////////////////////
  // read-back request and reply shift-out

  always_ff @(posedge clk)
  begin
    if (reset)
      rd_req <= 1'b0;
    else
      rd_req <= sck_rise && (bit_cnt == CNT_W'(ADDR_BITS - 1));
  end

  assign rd_addr = frame_sr[7:0];

  // mode 0, next bit goes out on falling sck
  always_ff @(posedge clk)
  begin
    if (reset || pins_s.cs_n)
    begin
      reply_sr <= '0;
      dout     <= 1'b0;
    end
    else if (rd_req)
      reply_sr <= rd_data;
    else if (sck_fall)
    begin
      dout     <= reply_sr[7];
      reply_sr <= {reply_sr[6:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////////////////
  // frame handoff

  // only an exact 16 bit frame counts
  assign frame_done = cs_rise && (bit_cnt == CNT_W'(`HUB_FRAME_BITS));
  // a pending frame not yet taken wins, the new one is lost
  assign load_frame = frame_done && (!frame_valid || frame_ready);

  always_ff @(posedge clk)
  begin
    if (load_frame)
      frame <= frame_sr;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      frame_valid <= 1'b0;
    else if (load_frame)
      frame_valid <= 1'b1;
    else if (frame_ready)
      frame_valid <= 1'b0;
  end

  // host must not finish a frame while the last one waits
  a_no_frame_drop: assert property (@(posedge clk) disable iff (reset)
    !(frame_done && frame_valid && !frame_ready));

  // read request is a single pulse per frame
  a_rd_req_pulse: assert property (@(posedge clk) disable iff (reset)
    rd_req |=> !rd_req);

endmodule

`default_nettype wire

/* hdl/ctrl_regs.sv */
// control register bank
// set/clear/toggle bit registers, one-hot mux select,
// soft-reset and power-up group clears, read-back

`default_nettype none
`timescale 1ns/1ns

`include "hub_consts.svh"

module ctrl_regs (
  input  wire                         clk,
  input  wire                         reset,
  input  spi_frame_pkg::spi_frame_t   frame,
  input  wire                         frame_valid,
  output logic                        frame_ready,
  input  wire  [7:0]                  rd_addr,
  input  wire                         rd_req,
  output logic [7:0]                  rd_data,
  output board_ctrl_pkg::ctrl_regs_t  regs
);

  import spi_frame_pkg::*;
  import board_ctrl_pkg::*;

  // dac comes up all high, everything else low
  localparam ctrl_regs_t REGS_INIT = '{led: 4'h0, mux: 8'h00, dac: 4'hf, adc: 4'h0};

  logic take;

  //////////////////////////////////////////////////////////////
  // update rules

  // overlap of set and clear toggles those bits
  // otherwise set then clear
  function automatic logic [3:0] update_bits(input logic [3:0] old, input frame_data_u d);
    logic [3:0] common;
    common = d.bits.set & d.bits.clear;
    if (common != 4'h0)
      update_bits = old ^ common;
    else
      update_bits = (old | d.bits.set) & ~d.bits.clear;
  endfunction

  // sel 1..8 picks bit sel-1, 0 and out of range give none
  function automatic logic [7:0] one_hot_sel(input frame_data_u d);
    if (d.sel >= 8'd1 && d.sel <= 8'd8)
      one_hot_sel = 8'h01 << (d.sel - 8'd1);
    else
      one_hot_sel = 8'h00;
  endfunction

  //////////////////////////////////////////////////////////////
  // register write

  // no back-pressure, a frame is taken the cycle it shows up
  assign frame_ready = 1'b1;
  assign take        = frame_valid && frame_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
      regs <= REGS_INIT;
    else if (take)
    begin
      case (frame.addr)
        `HUB_ADDR_LED: regs.led <= update_bits(regs.led, frame.data);
        `HUB_ADDR_MUX: regs.mux <= one_hot_sel(frame.data);
        `HUB_ADDR_DAC: regs.dac <= update_bits(regs.dac, frame.data);
        `HUB_ADDR_ADC: regs.adc <= update_bits(regs.adc, frame.data);
        `HUB_ADDR_SOFT_RESET:
        begin
          regs.led <= 4'h0;
          regs.mux <= 8'h00;
          regs.dac <= 4'h0;
          regs.adc <= 4'h0;
        end
        // rails coming up, dac setup and mux stay as they are
        `HUB_ADDR_POWERUP:
        begin
          regs.led <= 4'h0;
          regs.adc <= 4'h0;
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////
  // read-back

  // served mid-frame, so it shows the value before this frame's write
  always_comb
  begin
    rd_data = 8'h00;
    if (rd_req)
    begin
      case (rd_addr)
        `HUB_ADDR_LED: rd_data = {4'h0, regs.led};
        `HUB_ADDR_MUX: rd_data = regs.mux;
        `HUB_ADDR_DAC: rd_data = {4'h0, regs.dac};
        `HUB_ADDR_ADC: rd_data = {4'h0, regs.adc};
        default:       rd_data = 8'h00;
      endcase
    end
  end

  // router relies on this for a single active chip select
  a_mux_one_hot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(regs.mux));

endmodule

`default_nettype wire

/* hdl/spi_route.sv */
// spi chip-select and miso routing
// cs2 high, hub owns the bus; cs2 low, selected peripheral does

`default_nettype none
`timescale 1ns/1ns

`include "hub_consts.svh"

module spi_route (
  input  wire                         cs2_n,
  input  wire  [7:0]                  mux,
  input  wire                         dout,
  input  board_ctrl_pkg::periph_vec_t periph_miso,
  output board_ctrl_pkg::periph_vec_t periph_cs_n,
  output logic                        miso
);

  import board_ctrl_pkg::*;

  periph_vec_t sel;
  periph_vec_t miso_sel;

  //////////////////////////////////////////////////////////////
  // select decode

  // only the low mux bits have a peripheral behind them
  // upper bits select nothing
  assign sel = mux[`HUB_NUM_PERIPH-1:0];

  // masked miso of the selected peripheral
  assign miso_sel = sel & periph_miso;

  //////////////////////////////////////////////////////////////
  // chip selects

  // all idle high unless cs2 is asserted
  always_comb
  begin
    if (cs2_n)
      periph_cs_n = '1;
    else
      periph_cs_n = ~sel;
  end

  //////////////////////////////////////////////////////////////
  // miso return path

  // hub's own dout when cs2 is idle
  always_comb
  begin
    if (cs2_n)
      miso = dout;
    else
      miso = |miso_sel;
  end

  // never two peripherals driving the shared bus
  always_comb
  begin
    a_single_cs: assert final ($onehot0(~periph_cs_n));
  end

endmodule

`default_nettype wire

/* hdl/board_hub.sv */
// board control hub top level
// spi target, register bank, peripheral spi router, pin fan-out

`default_nettype none
`timescale 1ns/1ns

`include "hub_consts.svh"

module board_hub (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         sck,
  input  wire                         cs_n,
  input  wire                         cs2_n,
  input  wire                         mosi,
  output logic                        miso,
  output board_ctrl_pkg::periph_vec_t periph_cs_n,
  output board_ctrl_pkg::periph_vec_t periph_sck,
  output board_ctrl_pkg::periph_vec_t periph_mosi,
  input  board_ctrl_pkg::periph_vec_t periph_miso,
  output logic [3:0]                  led,
  output logic [3:0]                  dac_ctrl,
  output logic [3:0]                  adc_mode,
  input  wire                         adc_drdy_n,
  output logic                        irq_n
);

  import spi_frame_pkg::*;
  import board_ctrl_pkg::*;

  spi_frame_t frame;
  logic       frame_valid;
  logic       frame_ready;
  logic [7:0] rd_addr;
  logic       rd_req;
  logic [7:0] rd_data;
  logic       dout;
  ctrl_regs_t regs;

  //////////////////////////////////////////////////////////////
  // hub spi target and registers

  spi_target u_spi_target (
    .clk         (clk),
    .reset       (reset),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .dout        (dout),
    .frame       (frame),
    .frame_valid (frame_valid),
    .frame_ready (frame_ready),
    .rd_addr     (rd_addr),
    .rd_req      (rd_req),
    .rd_data     (rd_data)
  );

  ctrl_regs u_ctrl_regs (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .frame_ready (frame_ready),
    .rd_addr     (rd_addr),
    .rd_req      (rd_req),
    .rd_data     (rd_data),
    .regs        (regs)
  );

  //////////////////////////////////////////////////////////////
  // peripheral routing

  spi_route u_spi_route (
    .cs2_n       (cs2_n),
    .mux         (regs.mux),
    .dout        (dout),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  // sck and mosi straight through to every peripheral
  assign periph_sck  = {`HUB_NUM_PERIPH{sck}};
  assign periph_mosi = {`HUB_NUM_PERIPH{mosi}};

  // register fields out to board pins
  assign led      = regs.led;
  assign dac_ctrl = regs.dac;
  assign adc_mode = regs.adc;

  // adc data ready doubles as the mcu interrupt
  assign irq_n = adc_drdy_n;

endmodule

`default_nettype wire

/* tests/tb_board_hub.sv */
// board hub testbench
// spi host task, register model, compare tasks, directed tests, timeout

`default_nettype none
`timescale 1ns/1ns

`include "hub_consts.svh"

module tb_board_hub;

  import spi_frame_pkg::*;
  import board_ctrl_pkg::*;

  // about 100 frames of ~145 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        reset;
  logic        sck;
  logic        cs_n;
  logic        cs2_n;
  logic        mosi;
  logic        miso;
  periph_vec_t periph_cs_n;
  periph_vec_t periph_sck;
  periph_vec_t periph_mosi;
  periph_vec_t periph_miso;
  logic [3:0]  led;
  logic [3:0]  dac_ctrl;
  logic [3:0]  adc_mode;
  logic        adc_drdy_n;
  logic        irq_n;

  ctrl_regs_t  model;
  ctrl_regs_t  act;
  logic [7:0]  rb;
  logic [31:0] rng_state;
  int          cycle_count;
  int          reg_errs;
  int          byte_errs;
  int          route_errs;

  board_hub u_board_hub (
    .clk         (clk),
    .reset       (reset),
    .sck         (sck),
    .cs_n        (cs_n),
    .cs2_n       (cs2_n),
    .mosi        (mosi),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .periph_sck  (periph_sck),
    .periph_mosi (periph_mosi),
    .periph_miso (periph_miso),
    .led         (led),
    .dac_ctrl    (dac_ctrl),
    .adc_mode    (adc_mode),
    .adc_drdy_n  (adc_drdy_n),
    .irq_n       (irq_n)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // overlap toggles, else set then clear
  function automatic logic [3:0] bit_rule(input logic [3:0] old, input frame_data_u d);
    logic [3:0] both;
    both = d.bits.set & d.bits.clear;
    if (|both)
      return old ^ both;
    return (old | d.bits.set) & ~d.bits.clear;
  endfunction

  function automatic logic [7:0] mux_rule(input frame_data_u d);
    logic [7:0] m;
    m = 8'h00;
    if (d.sel != 8'd0 && d.sel <= 8'd8)
      m[d.sel - 8'd1] = 1'b1;
    return m;
  endfunction

  // sel value that rewrites the current one-hot mux
  function automatic logic [7:0] sel_of(input logic [7:0] m);
    logic [7:0] s;
    s = 8'h00;
    for (int i = 0; i < 8; i++)
      if (m[i])
        s = 8'(i + 1);
    return s;
  endfunction

  function automatic logic [7:0] reply_of(input logic [7:0] addr);
    case (addr)
      `HUB_ADDR_LED: return {4'h0, model.led};
      `HUB_ADDR_MUX: return model.mux;
      `HUB_ADDR_DAC: return {4'h0, model.dac};
      `HUB_ADDR_ADC: return {4'h0, model.adc};
      default:       return 8'h00;
    endcase
  endfunction

  task automatic model_write(input logic [7:0] addr, input frame_data_u d);
    case (addr)
      `HUB_ADDR_LED:        model.led = bit_rule(model.led, d);
      `HUB_ADDR_MUX:        model.mux = mux_rule(d);
      `HUB_ADDR_DAC:        model.dac = bit_rule(model.dac, d);
      `HUB_ADDR_ADC:        model.adc = bit_rule(model.adc, d);
      `HUB_ADDR_SOFT_RESET: model = '0;
      `HUB_ADDR_POWERUP:
      begin
        model.led = 4'h0;
        model.adc = 4'h0;
      end
      default: ;
    endcase
  endtask

  // mux is not on a pin, caller supplies it
  function automatic ctrl_regs_t pins_now(input logic [7:0] mux_val);
    ctrl_regs_t r;
    r.led = led;
    r.mux = mux_val;
    r.dac = dac_ctrl;
    r.adc = adc_mode;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks

  function automatic string format_regs(input ctrl_regs_t r);
    return $sformatf("led %h mux %h dac %h adc %h", r.led, r.mux, r.dac, r.adc);
  endfunction

  task automatic check_regs(input string name, input ctrl_regs_t exp, input ctrl_regs_t got);
    if (got !== exp)
    begin
      reg_errs++;
      $display("mismatch %s: expected %s actual %s", name, format_regs(exp), format_regs(got));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp)
    begin
      byte_errs++;
      $display("mismatch %s: expected %h actual %h", name, exp, got);
    end
  endtask

  task automatic check_route(input string name, input periph_vec_t exp, input periph_vec_t got);
    if (got !== exp)
    begin
      route_errs++;
      $display("mismatch %s: expected %b actual %b", name, exp, got);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // spi host, mode 0, msb first

  task automatic spi_xfer(input logic [15:0] word, input int nbits, output logic [7:0] reply);
    reply = 8'h00;
    cs_n  = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      sck  = 1'b0;
      mosi = word[15 - i];
      repeat (4) @(negedge clk);
      sck = 1'b1;
      // reply byte rides on bits 9..16
      if (i >= 8)
        reply = {reply[6:0], miso};
      repeat (4) @(negedge clk);
    end
    sck = 1'b0;
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
    // registers settle 4 cycles after cs release
    repeat (8) @(negedge clk);
  endtask

  task automatic hub_write(input string name, input logic [7:0] addr, input logic [7:0] data,
                           output logic [7:0] reply);
    logic [7:0] exp;
    exp = reply_of(addr);
    spi_xfer({addr, data}, 16, reply);
    check_byte(name, exp, reply);
    model_write(addr, data);
  endtask

  task automatic write_and_check(input string name, input logic [7:0] addr,
                                 input logic [7:0] data);
    logic [7:0] r;
    hub_write(name, addr, data, r);
    check_regs(name, model, pins_now(model.mux));
  endtask

  // pins plus mux via read-back, mux rewritten with its own value
  task automatic read_regs(input string name, output ctrl_regs_t got);
    logic [7:0] r;
    hub_write({name, " mux"}, `HUB_ADDR_MUX, sel_of(model.mux), r);
    got = pins_now(r);
  endtask

  task automatic check_routing(input string name, input logic cs2, input periph_vec_t pm);
    periph_vec_t exp_cs;
    logic        exp_miso;
    cs2_n       = cs2;
    periph_miso = pm;
    @(posedge clk);
    if (cs2)
    begin
      exp_cs   = '1;
      exp_miso = 1'b0;
    end
    else
    begin
      exp_cs   = ~model.mux[`HUB_NUM_PERIPH-1:0];
      exp_miso = |(model.mux[`HUB_NUM_PERIPH-1:0] & pm);
    end
    check_route(name, exp_cs, periph_cs_n);
    check_byte({name, " miso"}, {7'h0, exp_miso}, {7'h0, miso});
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_reset();
    read_regs("reset", act);
    check_regs("reset", model, act);
    check_routing("reset route", 1'b1, '0);
    check_route("reset sck fan-out", '0, periph_sck);
    check_route("reset mosi fan-out", '0, periph_mosi);
    // cs still released, so the hub itself ignores these
    sck  = 1'b1;
    mosi = 1'b1;
    @(posedge clk);
    check_route("sck fan-out high", '1, periph_sck);
    check_route("mosi fan-out high", '1, periph_mosi);
    @(negedge clk);
    sck  = 1'b0;
    mosi = 1'b0;
    // let the synchronizer see sck low before the next frame
    repeat (4) @(negedge clk);
  endtask

  task automatic test_bit_rules();
    logic [7:0] addrs [3];
    addrs = '{`HUB_ADDR_LED, `HUB_ADDR_DAC, `HUB_ADDR_ADC};
    write_and_check("led set", `HUB_ADDR_LED, 8'h0a);
    write_and_check("led clear", `HUB_ADDR_LED, 8'h20);
    write_and_check("dac clear", `HUB_ADDR_DAC, 8'h50);
    write_and_check("dac set", `HUB_ADDR_DAC, 8'h01);
    write_and_check("adc set", `HUB_ADDR_ADC, 8'h07);
    write_and_check("adc clear", `HUB_ADDR_ADC, 8'h30);
    // random bytes, overlapping nibbles exercise toggle
    for (int a = 0; a < 3; a++)
      repeat (20)
      begin
        rng_state = xorshift32(rng_state);
        write_and_check("bit random", addrs[a], rng_state[7:0]);
      end
    read_regs("bit rules", act);
    check_regs("bit rules", model, act);
  endtask

  // second write of each pair reads back the first
  task automatic test_readback();
    hub_write("readback led", `HUB_ADDR_LED, 8'h0c, rb);
    hub_write("readback led again", `HUB_ADDR_LED, 8'h00, rb);
    hub_write("readback dac", `HUB_ADDR_DAC, 8'h06, rb);
    hub_write("readback dac again", `HUB_ADDR_DAC, 8'h00, rb);
    hub_write("readback adc", `HUB_ADDR_ADC, 8'h0b, rb);
    hub_write("readback adc again", `HUB_ADDR_ADC, 8'h00, rb);
    hub_write("readback mux", `HUB_ADDR_MUX, 8'd2, rb);
    hub_write("readback mux again", `HUB_ADDR_MUX, 8'd2, rb);
    hub_write("readback unknown", 8'h03, 8'hff, rb);
    read_regs("readback", act);
    check_regs("readback", model, act);
  endtask

  task automatic test_mux_route();
    for (int s = 0; s <= 9; s++)
    begin
      hub_write("mux sel", `HUB_ADDR_MUX, 8'(s), rb);
      rng_state = xorshift32(rng_state);
      check_routing("route cs2 low", 1'b0, rng_state[`HUB_NUM_PERIPH-1:0]);
      // inverted pattern, selected miso seen both high and low
      check_routing("route cs2 low inverted", 1'b0, ~rng_state[`HUB_NUM_PERIPH-1:0]);
      check_routing("route cs2 high", 1'b1, rng_state[`HUB_NUM_PERIPH-1:0]);
    end
  endtask

  task automatic load_all(input string name);
    hub_write({name, " led"}, `HUB_ADDR_LED, 8'h0f, rb);
    hub_write({name, " mux"}, `HUB_ADDR_MUX, 8'd3, rb);
    hub_write({name, " dac"}, `HUB_ADDR_DAC, 8'h03, rb);
    hub_write({name, " adc"}, `HUB_ADDR_ADC, 8'h09, rb);
  endtask

  task automatic test_group_clear();
    load_all("soft reset setup");
    hub_write("soft reset", `HUB_ADDR_SOFT_RESET, 8'h00, rb);
    read_regs("soft reset", act);
    check_regs("soft reset", model, act);
    load_all("power-up setup");
    hub_write("power-up", `HUB_ADDR_POWERUP, 8'h00, rb);
    read_regs("power-up", act);
    check_regs("power-up", model, act);
  endtask

  task automatic test_short_frame_irq();
    // leaves a zero low nibble in the shifter
    hub_write("short frame setup", `HUB_ADDR_LED, 8'h00, rb);
    // 12 bits only, hub must drop it
    // taken anyway, the shifter would read as led set 0xf
    spi_xfer(16'h70f0, 12, rb);
    read_regs("short frame", act);
    check_regs("short frame", model, act);
    adc_drdy_n = 1'b0;
    @(posedge clk);
    check_byte("irq low", 8'h00, {7'h0, irq_n});
    @(negedge clk);
    adc_drdy_n = 1'b1;
    @(posedge clk);
    check_byte("irq high", 8'h01, {7'h0, irq_n});
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    clk         = 1'b0;
    reset       = 1'b1;
    sck         = 1'b0;
    cs_n        = 1'b1;
    cs2_n       = 1'b1;
    mosi        = 1'b0;
    periph_miso = '0;
    adc_drdy_n  = 1'b1;
    rng_state   = 32'd91792;
    cycle_count = 0;
    reg_errs    = 0;
    byte_errs   = 0;
    route_errs  = 0;
    // dac powers up all high
    model       = '{led: 4'h0, mux: 8'h00, dac: 4'hf, adc: 4'h0};
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    test_reset();
    test_bit_rules();
    test_readback();
    test_mux_route();
    test_group_clear();
    test_short_frame_irq();
    $display("errors: regs %0d, bytes %0d, route %0d", reg_errs, byte_errs, route_errs);
    if (reg_errs + byte_errs + route_errs == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/spi_frame_pkg.sv
hdl/board_ctrl_pkg.sv
hdl/spi_target.sv
hdl/ctrl_regs.sv
hdl/spi_route.sv
hdl/board_hub.sv
tests/tb_board_hub.sv
